//--- sprite_motion.f
verilog/sprite_pkg.sv
verilog/button_decode.sv
verilog/axis_mover.sv
verilog/sprite_render.sv
verilog/sprite_motion_top.sv
tests/sprite_motion_tb.sv

//--- Bender.yml
package:
  name: sprite_motion

sources:
  # package first, then leaf modules, then the top level
  - files:
      - verilog/sprite_pkg.sv
      - verilog/button_decode.sv
      - verilog/axis_mover.sv
      - verilog/sprite_render.sv
      - verilog/sprite_motion_top.sv

  # testbench, top module sprite_motion_tb
  - target: test
    files:
      - tests/sprite_motion_tb.sv

# RTL top level: sprite_motion_top
# testbench top level: sprite_motion_tb
# flat compile order is also given in sprite_motion.f

//--- tests/sprite_motion_tb.sv
`timescale 1ns/1ps

module sprite_motion_tb;

    localparam int TILE      = 16;                  // square tile
    localparam int T_START   = 12;                  // first step interval
    localparam int T_STEP    = 4;                   // interval shrink per step
    localparam int T_MIN     = 4;                   // fastest interval
    localparam int START_POS = 320;                 // both axes
    localparam int NUM_ROWS  = 12;
    localparam int RAMP_ROW  = 1;                   // btn_r alone
    localparam int LEFT_ROW  = 8;                   // long btn_l hold
    localparam int DOWN_ROW  = 10;                  // long btn_d hold

    typedef struct packed {
        logic        u;
        logic        d;
        logic        l;
        logic        r;
        logic        en;                            // sprite_enable level
        logic [15:0] hold;                          // cycles
    } row_t;

    logic                    clk;
    logic                    reset;
    logic                    btn_u;
    logic                    btn_d;
    logic                    btn_l;
    logic                    btn_r;
    logic                    video_on;
    logic                    sprite_enable;
    sprite_pkg::sprite_pos_t scan_pos;
    sprite_pkg::rgb_t        color_data;
    sprite_pkg::rgb_t        rgb_out;
    logic                    sprite_on;
    sprite_pkg::sprite_pos_t sprite_pos;
    sprite_pkg::facing_e     facing_x;
    sprite_pkg::facing_e     facing_y;
    sprite_pkg::coord_t      rom_col;
    sprite_pkg::coord_t      rom_row;

    row_t                    rows [NUM_ROWS];
    logic [31:0]             rng = 32'hac33;        // xorshift state
    int                      cyc = 0;               // edges seen by the main loop
    int                      wd_cycles = 0;
    int                      wd_limit = 0;
    int                      ramp_start;            // cycle the btn_r row was driven
    int                      last_x;                // DUT x after the previous edge
    int                      step_q [$];            // cycles of x steps in the ramp row

    // reference model state, index 0 is x and 1 is y
    int                      m_pos [2];
    int                      m_cnt [2];
    int                      m_rel [2];
    sprite_pkg::axis_state_e m_st [2];
    sprite_pkg::facing_e     m_face_x;
    sprite_pkg::facing_e     m_face_y;

    sprite_motion_top #(
        .TILE_W     (TILE),
        .TILE_H     (TILE),
        .START_X    (START_POS),
        .START_Y    (START_POS),
        .TIME_START (20'(T_START)),
        .TIME_STEP  (20'(T_STEP)),
        .TIME_MIN   (20'(T_MIN))
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .btn_u         (btn_u),
        .btn_d         (btn_d),
        .btn_l         (btn_l),
        .btn_r         (btn_r),
        .video_on      (video_on),
        .sprite_enable (sprite_enable),
        .scan_pos      (scan_pos),
        .color_data    (color_data),
        .rgb_out       (rgb_out),
        .sprite_on     (sprite_on),
        .sprite_pos    (sprite_pos),
        .facing_x      (facing_x),
        .facing_y      (facing_y),
        .rom_col       (rom_col),
        .rom_row       (rom_row)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic add_row(input int i, input logic u, input logic d, input logic l,
                           input logic r, input logic en, input int hold);
        rows[i].u    = u;
        rows[i].d    = d;
        rows[i].l    = l;
        rows[i].r    = r;
        rows[i].en   = en;
        rows[i].hold = 16'(hold);
    endtask

    task automatic load_table();
        add_row(0,  0, 0, 0, 0, 0, 10);             // idle, sprite hidden
        add_row(1,  0, 0, 0, 1, 1, 60);             // right, speed ramp
        add_row(2,  0, 0, 0, 0, 1, 20);             // released, mirrored column
        add_row(3,  0, 0, 1, 1, 1, 20);             // opposing, no motion
        add_row(4,  0, 1, 0, 0, 1, 30);             // down a little
        add_row(5,  0, 0, 0, 0, 1, 20);             // mirrored row
        add_row(6,  1, 0, 0, 0, 1, 40);             // up, facing_y back to neg
        add_row(7,  0, 0, 0, 0, 1, 20);
        add_row(8,  0, 0, 1, 0, 1, 1800);           // run into the left edge
        add_row(9,  0, 0, 0, 0, 1, 30);
        add_row(10, 0, 1, 0, 0, 1, 900);            // run into the bottom edge
        add_row(11, 0, 0, 0, 0, 1, 30);
    endtask

    // one axis of the motion rule, applied at a clock edge
    task automatic step_axis(input int a, input logic want_neg, input logic want_pos);
        int   lo;
        int   hi;
        logic held;
        lo = (a == 0) ? 0 : sprite_pkg::MIN_Y;
        hi = (a == 0) ? sprite_pkg::SCREEN_W - TILE : sprite_pkg::SCREEN_H - TILE;
        if (m_st[a] == sprite_pkg::idle)
        begin
            if (want_neg && m_pos[a] > lo)
            begin
                m_st[a]  = sprite_pkg::move_neg;
                m_cnt[a] = T_START;
                m_rel[a] = T_START;
            end
            else if (want_pos && m_pos[a] + 1 < hi)
            begin
                m_st[a]  = sprite_pkg::move_pos;
                m_cnt[a] = T_START;
                m_rel[a] = T_START;
            end
        end
        else
        begin
            held = (m_st[a] == sprite_pkg::move_neg) ? want_neg : want_pos;
            if (!held)
                m_st[a] = sprite_pkg::idle;         // stop, no last step
            else if (m_cnt[a] > 0)
                m_cnt[a] = m_cnt[a] - 1;
            else
            begin
                if (m_st[a] == sprite_pkg::move_neg && m_pos[a] > lo)
                    m_pos[a] = m_pos[a] - 1;
                else if (m_st[a] == sprite_pkg::move_pos && m_pos[a] + 1 < hi)
                    m_pos[a] = m_pos[a] + 1;
                m_rel[a] = (m_rel[a] - T_STEP > T_MIN) ? m_rel[a] - T_STEP : T_MIN;
                m_cnt[a] = m_rel[a];
            end
        end
    endtask

    task automatic step_model();
        logic xn;
        logic xp;
        logic yn;
        logic yp;
        xn = btn_l && !btn_r;                       // opposing buttons cancel
        xp = btn_r && !btn_l;
        yn = btn_u && !btn_d;
        yp = btn_d && !btn_u;
        step_axis(0, xn, xp);
        step_axis(1, yn, yp);
        if (xn)
            m_face_x = sprite_pkg::face_neg;
        else if (xp)
            m_face_x = sprite_pkg::face_pos;
        if (yn)
            m_face_y = sprite_pkg::face_neg;
        else if (yp)
            m_face_y = sprite_pkg::face_pos;
    endtask

    task automatic check_motion();
        compare("sprite_pos.x", sprite_pos.x, m_pos[0]);
        compare("sprite_pos.y", sprite_pos.y, m_pos[1]);
        compare("facing_x", facing_x, m_face_x);
        compare("facing_y", facing_y, m_face_y);
    endtask

    task automatic check_render();
        int         ox;
        int         oy;
        logic       hit;
        logic       draw;
        logic [9:0] col;
        logic [9:0] row;
        ox   = int'(scan_pos.x) - m_pos[0];         // offset into the tile
        oy   = int'(scan_pos.y) - m_pos[1];
        hit  = (ox >= 0) && (ox < TILE) && (oy >= 0) && (oy < TILE);
        draw = hit && video_on && sprite_enable;
        col  = (m_face_x == sprite_pkg::face_neg) ? 10'(ox) : 10'(TILE - 1 - ox);
        row  = (m_face_y == sprite_pkg::face_neg) ? 10'(oy) : 10'(TILE - 1 - oy);
        compare("rom_col", rom_col, col);
        compare("rom_row", rom_row, row);
        compare("rgb_out", rgb_out, draw ? color_data : 12'h000);
        compare("sprite_on", sprite_on, draw && (color_data != sprite_pkg::TRANSPARENT_RGB));
    endtask

    task automatic drive_row(input int i);
        logic [31:0] r;
        btn_u         = rows[i].u;
        btn_d         = rows[i].d;
        btn_l         = rows[i].l;
        btn_r         = rows[i].r;
        sprite_enable = rows[i].en;
        if (!(rows[i].u || rows[i].d || rows[i].l || rows[i].r))
        begin
            rng = xorshift(rng);
            r   = rng;
            if (r[0])
            begin
                scan_pos.x = 10'(m_pos[0] + r[7:4]); // inside the tile
                scan_pos.y = 10'(m_pos[1] + r[11:8]);
            end
            else
            begin
                scan_pos.x = 10'(r[21:12] % sprite_pkg::SCREEN_W);
                scan_pos.y = 10'(r[31:22] % sprite_pkg::SCREEN_H);
            end
            rng        = xorshift(rng);
            color_data = (rng[1:0] == 2'b00) ? sprite_pkg::TRANSPARENT_RGB : rng[13:2];
            video_on   = rng[14] | rng[15];         // mostly visible
        end
    endtask

    // watchdog on total run length
    always @(posedge clk)
    begin
        wd_cycles = wd_cycles + 1;
        if (wd_limit > 0 && wd_cycles > wd_limit)
        begin
            $display("timeout: run went past %0d cycles", wd_limit);
            abort_run();
        end
    end

    initial
    begin
        reset         = 1'b1;
        btn_u         = 1'b0;
        btn_d         = 1'b0;
        btn_l         = 1'b0;
        btn_r         = 1'b0;
        video_on      = 1'b0;
        sprite_enable = 1'b0;
        scan_pos      = '0;
        color_data    = '0;
        load_table();
        wd_limit = 100;
        for (int i = 0; i < NUM_ROWS; i++)
            wd_limit = wd_limit + rows[i].hold;
        for (int a = 0; a < 2; a++)
        begin
            m_pos[a] = START_POS;
            m_cnt[a] = 0;
            m_rel[a] = 0;
            m_st[a]  = sprite_pkg::idle;
        end
        m_face_x = sprite_pkg::face_pos;
        m_face_y = sprite_pkg::face_neg;

        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        check_motion();                             // reset values
        compare("sprite_on", sprite_on, 0);
        last_x = int'(sprite_pos.x);

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            for (int k = 0; k < rows[i].hold; k++)
            begin
                @(posedge clk);
                cyc = cyc + 1;
                step_model();
                #1;
                check_motion();
                if (i == RAMP_ROW && k > 0 && int'(sprite_pos.x) != last_x)
                    step_q.push_back(cyc);          // x stepped at this edge
                last_x = int'(sprite_pos.x);
                drive_row(i);
                if (k == 0)
                    ramp_start = cyc;
                #1;
                check_render();
            end
            if (i == RAMP_ROW)
            begin
                if (step_q.size() < 3)
                begin
                    $display("fewer than three x steps while btn_r was held");
                    abort_run();
                end
                compare("first x step gap", step_q[0] - (ramp_start + 1), T_START + 1);
                compare("second x step gap", step_q[1] - step_q[0], T_START - T_STEP + 1);
                compare("third x step gap", step_q[2] - step_q[1], T_MIN + 1);
            end
            if (i == LEFT_ROW)
                compare("sprite_pos.x", sprite_pos.x, 0);
            if (i == DOWN_ROW)
                compare("sprite_pos.y", sprite_pos.y, sprite_pkg::SCREEN_H - TILE - 1);
        end

        @(posedge clk);
        step_model();
        #1;
        check_motion();
        $display("sim passed");
        $finish;
    end

endmodule

//--- verilog/sprite_motion_top.sv
`timescale 1ns/1ps

module sprite_motion_top
#(
    parameter int                TILE_W     = 16,          // tile columns
    parameter int                TILE_H     = 16,          // tile rows
    parameter int                START_X    = 320,         // x after reset
    parameter int                START_Y    = 320,         // y after reset
    parameter sprite_pkg::time_t TIME_START = 20'd800000,  // first step interval
    parameter sprite_pkg::time_t TIME_STEP  = 20'd6000,    // interval shrink per step
    parameter sprite_pkg::time_t TIME_MIN   = 20'd500000   // fastest interval
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    btn_u,
    input  logic                    btn_d,
    input  logic                    btn_l,
    input  logic                    btn_r,
    input  logic                    video_on,       // from the sync generator
    input  logic                    sprite_enable,
    input  sprite_pkg::sprite_pos_t scan_pos,       // current pixel
    input  sprite_pkg::rgb_t        color_data,     // tile ROM word
    output sprite_pkg::rgb_t        rgb_out,
    output logic                    sprite_on,
    output sprite_pkg::sprite_pos_t sprite_pos,     // tile top-left corner
    output sprite_pkg::facing_e     facing_x,
    output sprite_pkg::facing_e     facing_y,
    output sprite_pkg::coord_t      rom_col,
    output sprite_pkg::coord_t      rom_row
);

    sprite_pkg::axis_cmd_t cmd_x;                   // decoded x request
    sprite_pkg::axis_cmd_t cmd_y;                   // decoded y request
    sprite_pkg::axis_cmd_t axis_cmd [sprite_pkg::AXIS_X:sprite_pkg::AXIS_Y]; // indexed by axis
    sprite_pkg::coord_t    axis_pos [sprite_pkg::AXIS_X:sprite_pkg::AXIS_Y]; // mover outputs

    button_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .btn_u    (btn_u),
        .btn_d    (btn_d),
        .btn_l    (btn_l),
        .btn_r    (btn_r),
        .cmd_x    (cmd_x),
        .cmd_y    (cmd_y),
        .facing_x (facing_x),
        .facing_y (facing_y)
    );

    assign axis_cmd[sprite_pkg::AXIS_X] = cmd_x;
    assign axis_cmd[sprite_pkg::AXIS_Y] = cmd_y;

    // same mover on both axes, only the limits differ
    for (genvar i = sprite_pkg::AXIS_X; i <= sprite_pkg::AXIS_Y; i++)
    begin : g_axis
        localparam bit IS_X      = (i == sprite_pkg::AXIS_X);
        localparam int POS_MIN   = IS_X ? 0 : sprite_pkg::MIN_Y;
        localparam int POS_MAX   = IS_X ? sprite_pkg::SCREEN_W - TILE_W
                                        : sprite_pkg::SCREEN_H - TILE_H;
        localparam int POS_START = IS_X ? START_X : START_Y;

        axis_mover #(
            .TIME_START (TIME_START),
            .TIME_STEP  (TIME_STEP),
            .TIME_MIN   (TIME_MIN),
            .POS_MIN    (POS_MIN),
            .POS_MAX    (POS_MAX),
            .POS_START  (POS_START)
        ) u_mover (
            .clk   (clk),
            .reset (reset),
            .cmd   (axis_cmd[i]),
            .pos   (axis_pos[i])
        );
    end

    assign sprite_pos.x = axis_pos[sprite_pkg::AXIS_X];
    assign sprite_pos.y = axis_pos[sprite_pkg::AXIS_Y];

    sprite_render #(
        .TILE_W (TILE_W),
        .TILE_H (TILE_H)
    ) u_render (
        .scan_pos      (scan_pos),
        .sprite_pos    (sprite_pos),
        .facing_x      (facing_x),
        .facing_y      (facing_y),
        .video_on      (video_on),
        .sprite_enable (sprite_enable),
        .color_data    (color_data),
        .rgb_out       (rgb_out),
        .sprite_on     (sprite_on),
        .rom_col       (rom_col),
        .rom_row       (rom_row)
    );

endmodule

//--- verilog/sprite_render.sv
`timescale 1ns/1ps

module sprite_render
#(
    parameter int TILE_W = 16,                      // tile columns
    parameter int TILE_H = 16                       // tile rows
)
(
    input  sprite_pkg::sprite_pos_t scan_pos,       // pixel being scanned out
    input  sprite_pkg::sprite_pos_t sprite_pos,     // tile top-left corner
    input  sprite_pkg::facing_e     facing_x,       // horizontal mirror select
    input  sprite_pkg::facing_e     facing_y,       // vertical mirror select
    input  logic                    video_on,       // inside the visible area
    input  logic                    sprite_enable,  // sprite shown at all
    input  sprite_pkg::rgb_t        color_data,     // ROM word at rom_row / rom_col
    output sprite_pkg::rgb_t        rgb_out,        // masked sprite colour
    output logic                    sprite_on,      // sprite pixel wins over the background
    output sprite_pkg::coord_t      rom_col,        // ROM column index
    output sprite_pkg::coord_t      rom_row         // ROM row index
);

    logic               hit_x;                      // scan column inside the tile
    logic               hit_y;                      // scan row inside the tile
    logic               draw;                       // pixel comes from the ROM
    sprite_pkg::coord_t off_x;                      // column offset into the tile
    sprite_pkg::coord_t off_y;                      // row offset into the tile

    // 32-bit compare so the right / bottom edge cannot wrap
    assign hit_x = (scan_pos.x >= sprite_pos.x) && (scan_pos.x < sprite_pos.x + TILE_W);
    assign hit_y = (scan_pos.y >= sprite_pos.y) && (scan_pos.y < sprite_pos.y + TILE_H);

    assign off_x = scan_pos.x - sprite_pos.x;       // only meaningful on a hit
    assign off_y = scan_pos.y - sprite_pos.y;

    // the ROM art faces left and up, so face_pos reads it mirrored
    assign rom_col = (facing_x == sprite_pkg::face_neg)
                   ? off_x
                   : sprite_pkg::coord_t'(TILE_W - 1) - off_x;
    assign rom_row = (facing_y == sprite_pkg::face_neg)
                   ? off_y
                   : sprite_pkg::coord_t'(TILE_H - 1) - off_y;

    assign draw = hit_x && hit_y && video_on && sprite_enable;

    assign rgb_out   = draw ? color_data : '0;      // black outside the tile
    assign sprite_on = draw && (color_data != sprite_pkg::TRANSPARENT_RGB); // key colour shows background

endmodule

//--- verilog/axis_mover.sv
`timescale 1ns/1ps

module axis_mover
#(
    parameter sprite_pkg::time_t TIME_START = 20'd800000,  // first countdown after a press
    parameter sprite_pkg::time_t TIME_STEP  = 20'd6000,    // reload shrink per step
    parameter sprite_pkg::time_t TIME_MIN   = 20'd500000,  // fastest reload
    parameter int                POS_MIN    = 0,           // lowest legal position
    parameter int                POS_MAX    = 624,         // position must stay below this
    parameter int                POS_START  = 320          // position after reset
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  sprite_pkg::axis_cmd_t cmd,              // one-hot or empty request
    output sprite_pkg::coord_t    pos               // current sprite coordinate
);

    sprite_pkg::axis_state_e state_reg, state_next; // motion FSM
    sprite_pkg::coord_t      pos_reg, pos_next;     // sprite coordinate
    sprite_pkg::time_t       count_reg, count_next; // cycles left until the next step
    sprite_pkg::time_t       reload_reg, reload_next; // current step interval

    logic              can_neg;                     // one step toward POS_MIN is legal
    logic              can_pos;                     // one step toward POS_MAX is legal
    logic              hold_dir;                    // request still matches current direction
    sprite_pkg::time_t reload_ramp;                 // shortened interval for the next step

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state_reg  <= sprite_pkg::idle;
            pos_reg    <= sprite_pkg::coord_t'(POS_START);
            count_reg  <= '0;
            reload_reg <= '0;
        end
        else
        begin
            state_reg  <= state_next;
            pos_reg    <= pos_next;
            count_reg  <= count_next;
            reload_reg <= reload_next;
        end
    end

    assign can_neg  = pos_reg > POS_MIN;            // left / top edge
    assign can_pos  = pos_reg + 1 < POS_MAX;        // right / bottom edge, tile width included
    assign hold_dir = (state_reg == sprite_pkg::move_neg) ? cmd.neg : cmd.pos;

    // momentum: each step shortens the interval, floored at TIME_MIN
    // written as a difference so a large TIME_STEP cannot wrap
    assign reload_ramp = (reload_reg > TIME_MIN && reload_reg - TIME_MIN >= TIME_STEP)
                       ? reload_reg - TIME_STEP
                       : TIME_MIN;

    always_comb
    begin
        state_next  = state_reg;                    // hold by default
        pos_next    = pos_reg;
        count_next  = count_reg;
        reload_next = reload_reg;

        case (state_reg)
            sprite_pkg::idle:
            begin
                if (cmd.neg && can_neg)
                begin
                    state_next  = sprite_pkg::move_neg;
                    count_next  = TIME_START;       // slow start
                    reload_next = TIME_START;
                end
                else if (cmd.pos && can_pos)
                begin
                    state_next  = sprite_pkg::move_pos;
                    count_next  = TIME_START;
                    reload_next = TIME_START;
                end
            end

            sprite_pkg::move_neg, sprite_pkg::move_pos:
            begin
                if (!hold_dir)
                    state_next = sprite_pkg::idle;  // released, stop without a final step
                else if (count_reg != '0)
                    count_next = count_reg - 1'b1;  // still waiting
                else
                begin
                    if (state_reg == sprite_pkg::move_neg && can_neg)
                        pos_next = pos_reg - 1'b1;
                    else if (state_reg == sprite_pkg::move_pos && can_pos)
                        pos_next = pos_reg + 1'b1;
                    reload_next = reload_ramp;      // speed up
                    count_next  = reload_ramp;
                end
            end

            default:
                state_next = sprite_pkg::idle;      // unused encoding
        endcase
    end

    assign pos = pos_reg;

    // screen limits hold no matter how the requests arrive
    a_pos_in_bounds: assert property (
        @(posedge clk) disable iff (reset)
        (pos_reg >= POS_MIN) && (pos_reg <= POS_MAX - 1)
    ) else $error("position %0d left the legal range", pos_reg);

    // reload only moves between the start value and the floor
    a_reload_range: assert property (
        @(posedge clk) disable iff (reset)
        (state_reg != sprite_pkg::idle) |-> (reload_reg >= TIME_MIN) &&
                                            (reload_reg <= TIME_START)
    ) else $error("reload %0d outside ramp range", reload_reg);

endmodule

//--- verilog/button_decode.sv
`timescale 1ns/1ps

module button_decode
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   btn_u,           // up, negative y
    input  logic                   btn_d,           // down, positive y
    input  logic                   btn_l,           // left, negative x
    input  logic                   btn_r,           // right, positive x
    output sprite_pkg::axis_cmd_t  cmd_x,           // resolved x request
    output sprite_pkg::axis_cmd_t  cmd_y,           // resolved y request
    output sprite_pkg::facing_e    facing_x,        // last x direction asked for
    output sprite_pkg::facing_e    facing_y         // last y direction asked for
);

    // opposing buttons cancel, so both held looks the same as none held
    assign cmd_x.neg = btn_l && !btn_r;             // left only
    assign cmd_x.pos = btn_r && !btn_l;             // right only
    assign cmd_y.neg = btn_u && !btn_d;             // up only
    assign cmd_y.pos = btn_d && !btn_u;             // down only

    // facing follows any non-empty request, otherwise holds
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            facing_x <= sprite_pkg::face_pos;       // sprite starts looking right
            facing_y <= sprite_pkg::face_neg;       // and upright
        end
        else
        begin
            if (cmd_x.neg)
                facing_x <= sprite_pkg::face_neg;
            else if (cmd_x.pos)
                facing_x <= sprite_pkg::face_pos;

            if (cmd_y.neg)
                facing_y <= sprite_pkg::face_neg;
            else if (cmd_y.pos)
                facing_y <= sprite_pkg::face_pos;
        end
    end

    // the movers rely on never seeing both directions at once
    a_cmd_onehot: assert property (
        @(posedge clk) disable iff (reset)
        !(cmd_x.neg && cmd_x.pos) && !(cmd_y.neg && cmd_y.pos)
    ) else $error("both directions requested on one axis");

endmodule

//--- verilog/sprite_pkg.sv
package sprite_pkg;

    typedef logic [9:0]  coord_t;                   // pixel coordinate, either axis
    typedef logic [11:0] rgb_t;                     // 4-4-4 colour word
    typedef logic [19:0] time_t;                    // momentum countdown / reload value

    // per-axis motion request, at most one bit set after decode
    typedef struct packed {
        logic neg;                                  // toward smaller coords (left / up)
        logic pos;                                  // toward larger coords (right / down)
    } axis_cmd_t;

    typedef enum logic [1:0] {
        idle     = 2'd0,                            // no motion
        move_neg = 2'd1,                            // stepping toward smaller coords
        move_pos = 2'd2                             // stepping toward larger coords
    } axis_state_e;

    typedef enum logic {
        face_neg = 1'b0,                            // left on x, up on y
        face_pos = 1'b1                             // right on x, down on y
    } facing_e;

    // top-left corner of the sprite, or the current scan pixel
    typedef struct packed {
        coord_t x;                                  // column
        coord_t y;                                  // row
    } sprite_pos_t;

    localparam int SCREEN_W = 640;                  // visible columns
    localparam int SCREEN_H = 480;                  // visible rows
    localparam int MIN_Y    = 16;                   // top limit, keeps clear of the status strip

    localparam rgb_t TRANSPARENT_RGB = 12'h6DE;     // background key in the tile ROM

    localparam int AXIS_X = 0;                      // mover index for x
    localparam int AXIS_Y = 1;                      // mover index for y

endpackage
